/* common/fft_stream_defines.svh */
// Frame size, counter width and pad word of the FFT input streamer, included by RTL and testbench
`ifndef FFT_STREAM_DEFINES_SVH
`define FFT_STREAM_DEFINES_SVH

// Beats in one frame, half of an FFT block
`define CC_FRAME_LEN 128

// Wide enough to index every beat of one frame
`define CC_COUNT_W 8

// Word sent on every beat of the pad frame
`define CC_PAD_VALUE 32'd512

`endif

/* common/fft_stream_pkg.sv */
// Beat and frame command types shared by the streamer blocks and the testbench
package fft_stream_pkg;

    // One beat of the data stream toward the FFT core
    typedef struct packed {
        logic [31:0] data;
        // High only on the final beat of a block
        logic        last;
    } cc_beat_t;

    // Frame request from the sequencer to the sample streamer
    typedef struct packed {
        // One-cycle strobe that opens a frame
        logic start;
        // Frame carries pad words, not ring samples
        logic pad;
        // Second frame of the block, so its last beat closes the block
        logic final_frame;
    } cc_frame_cmd_t;

endpackage

/* verilog/fft_config_master.sv */
// One-time FFT configuration handshake after reset, reports completion to the frame sequencer
`timescale 1ns/1ps

module fft_config_master (
    input  logic clk,
    input  logic reset_b,
    input  logic config_ready,
    output logic config_valid,
    output logic config_done
);

    // Request goes up on the first edge after reset and stays up until accepted
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            config_valid <= 1'b0;
            config_done  <= 1'b0;
        end else if (config_valid) begin
            if (config_ready) begin
                config_valid <= 1'b0;
                config_done  <= 1'b1;
            end
        end else if (!config_done) begin
            config_valid <= 1'b1;
        end
    end

    // Request is held until the core accepts it
    a_valid_held: assert property (
        @(posedge clk) disable iff (!reset_b)
        config_valid && !config_ready |=> config_valid
    );

endmodule

/* cc_stream/cc_frame_sequencer.sv */
// Block FSM that waits for start and configuration, then requests the data and pad frames
`timescale 1ns/1ps

module cc_frame_sequencer
    import fft_stream_pkg::*;
#(
    // 0 puts the pad frame first, 1 puts it second
    parameter int ZERO_PAD = 1
) (
    input  logic          clk,
    input  logic          reset_b,
    input  logic          start,
    input  logic          config_done,
    input  logic          frame_done,
    output cc_frame_cmd_t frame_cmd
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_CFG,
        SEQ_FRAME_1,
        SEQ_FRAME_2
    } seq_state_t;

    // Pad flag of each frame follows the pad order
    localparam cc_frame_cmd_t FIRST_CMD = '{
        start:       1'b1,
        pad:         (ZERO_PAD == 0),
        final_frame: 1'b0
    };
    localparam cc_frame_cmd_t SECOND_CMD = '{
        start:       1'b1,
        pad:         (ZERO_PAD != 0),
        final_frame: 1'b1
    };

    seq_state_t    state;
    seq_state_t    state_next;
    cc_frame_cmd_t cmd_next;

    always_comb begin
        state_next     = state;
        cmd_next       = frame_cmd;
        // Start is a single-cycle strobe
        cmd_next.start = 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (start) begin
                    if (config_done) begin
                        state_next = SEQ_FRAME_1;
                        cmd_next   = FIRST_CMD;
                    end else begin
                        state_next = SEQ_WAIT_CFG;
                    end
                end
            end
            SEQ_WAIT_CFG: begin
                if (config_done) begin
                    state_next = SEQ_FRAME_1;
                    cmd_next   = FIRST_CMD;
                end
            end
            SEQ_FRAME_1: begin
                if (frame_done) begin
                    state_next = SEQ_FRAME_2;
                    cmd_next   = SECOND_CMD;
                end
            end
            SEQ_FRAME_2: begin
                if (frame_done) begin
                    state_next = SEQ_IDLE;
                    cmd_next   = '0;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
                cmd_next   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state     <= SEQ_IDLE;
            frame_cmd <= '0;
        end else begin
            state     <= state_next;
            frame_cmd <= cmd_next;
        end
    end

    // No new frame is requested until the streamer finishes the current one
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!reset_b)
        frame_cmd.start |=> (!frame_cmd.start) until frame_done
    );

endmodule

/* cc_stream/cc_sample_streamer.sv */
// Streams one frame of ring samples or pad words to the FFT core under valid/ready flow control
`timescale 1ns/1ps

`include "fft_stream_defines.svh"

module cc_sample_streamer
    import fft_stream_pkg::*;
(
    input  logic          clk,
    input  logic          reset_b,
    input  cc_frame_cmd_t frame_cmd,
    input  logic [31:0]   ring_data,
    input  logic          data_ready,
    output logic          data_valid,
    output cc_beat_t      data_beat,
    output logic          ring_advance,
    output logic          frame_done
);

    localparam logic [`CC_COUNT_W-1:0] LAST_IDX = `CC_FRAME_LEN - 1;

    logic [`CC_COUNT_W-1:0] beat_cnt;
    logic                   pad_q;
    logic                   final_q;
    logic                   xfer;
    logic                   load_next;

    assign xfer       = data_valid && data_ready;
    assign frame_done = xfer && (beat_cnt == LAST_IDX);
    // Next beat is loaded on every transfer except the last of the frame
    assign load_next  = xfer && (beat_cnt != LAST_IDX);

    // Ring moves on each time a sample is taken into the output register
    assign ring_advance = (frame_cmd.start && !frame_cmd.pad) || (load_next && !pad_q);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            data_valid <= 1'b0;
            beat_cnt   <= '0;
            pad_q      <= 1'b0;
            final_q    <= 1'b0;
        end else if (frame_cmd.start) begin
            data_valid <= 1'b1;
            beat_cnt   <= '0;
            pad_q      <= frame_cmd.pad;
            final_q    <= frame_cmd.final_frame;
        end else if (frame_done) begin
            data_valid <= 1'b0;
        end else if (load_next) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Output register holds its beat while the core stalls
    always_ff @(posedge clk) begin
        if (frame_cmd.start) begin
            data_beat.data <= frame_cmd.pad ? `CC_PAD_VALUE : ring_data;
            data_beat.last <= frame_cmd.final_frame && (LAST_IDX == '0);
        end else if (load_next) begin
            data_beat.data <= pad_q ? `CC_PAD_VALUE : ring_data;
            // Beat being loaded is the last one when the count sits one short
            data_beat.last <= final_q && (beat_cnt == LAST_IDX - 1'b1);
        end
    end

    // Stalled beat keeps its payload until it is taken
    a_beat_stable: assert property (
        @(posedge clk) disable iff (!reset_b)
        data_valid && !data_ready |=> data_valid && $stable(data_beat)
    );

endmodule

/* verilog/cc_stream_top.sv */
// Top of the FFT input streamer, joins config handshake, frame sequencer and sample streamer
`timescale 1ns/1ps

module cc_stream_top
    import fft_stream_pkg::*;
#(
    // 0 sends the pad frame first, 1 sends it after the data frame
    parameter int ZERO_PAD = 1
) (
    input  logic        clk,
    input  logic        reset_b,

    // Configuration handshake with the FFT core
    output logic        config_valid,
    input  logic        config_ready,

    // Level request for one block
    input  logic        start,

    // Sample stream into the FFT core
    output logic        data_valid,
    input  logic        data_ready,
    output cc_beat_t    data_beat,

    // External ring buffer
    input  logic [31:0] ring_data,
    output logic        ring_advance
);

    logic          config_done;
    cc_frame_cmd_t frame_cmd;
    logic          frame_done;

    fft_config_master fft_config_master_i (
        .clk          (clk),
        .reset_b      (reset_b),
        .config_ready (config_ready),
        .config_valid (config_valid),
        .config_done  (config_done)
    );

    cc_frame_sequencer #(
        .ZERO_PAD (ZERO_PAD)
    ) cc_frame_sequencer_i (
        .clk         (clk),
        .reset_b     (reset_b),
        .start       (start),
        .config_done (config_done),
        .frame_done  (frame_done),
        .frame_cmd   (frame_cmd)
    );

    cc_sample_streamer cc_sample_streamer_i (
        .clk          (clk),
        .reset_b      (reset_b),
        .frame_cmd    (frame_cmd),
        .ring_data    (ring_data),
        .data_ready   (data_ready),
        .data_valid   (data_valid),
        .data_beat    (data_beat),
        .ring_advance (ring_advance),
        .frame_done   (frame_done)
    );

endmodule

/* verif/cc_stream_tb.sv */
// Self-checking testbench for the FFT input streamer, random flow control against a ring model
`timescale 1ns/1ps

`include "fft_stream_defines.svh"

module cc_stream_tb
    import fft_stream_pkg::*;
#(
    // 1 sends the pad frame after the data frame, 0 before it
    parameter int ZERO_PAD = 1
);

    localparam int BLOCK_LEN     = 2 * `CC_FRAME_LEN;
    localparam int BLOCK_TIMEOUT = 8 * BLOCK_LEN;
    localparam int BURST_BLOCKS  = 4;

    logic        clk;
    logic        reset_b;
    logic        config_valid;
    logic        config_ready;
    logic        start;
    logic        data_valid;
    logic        data_ready;
    cc_beat_t    data_beat;
    logic [31:0] ring_data;
    logic        ring_advance;

    logic [31:0] lfsr_state;
    // Ring samples taken by the DUT and not yet seen on the stream
    logic [31:0] exp_ring[$];
    logic        advance_pending;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          test_errors_base;
    int          cfg_wait;
    int          hs_count;
    int          blocks_done;
    int          beat_idx;
    int          block_advances;
    logic        prev_valid;
    logic        prev_ready;
    cc_beat_t    prev_beat;
    logic        prev_cfg_valid;
    logic        prev_cfg_ready;

    cc_stream_top #(
        .ZERO_PAD (ZERO_PAD)
    ) cc_stream_top_i (
        .clk          (clk),
        .reset_b      (reset_b),
        .config_valid (config_valid),
        .config_ready (config_ready),
        .start        (start),
        .data_valid   (data_valid),
        .data_ready   (data_ready),
        .data_beat    (data_beat),
        .ring_data    (ring_data),
        .ring_advance (ring_advance)
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per random bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_errors_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("%-20s : fail, %0d errors", name, errs);
        end else begin
            $display("%-20s : pass", name);
        end
        test_errors_base = error_count;
    endtask

    // Waits are checked just after the edge, where DUT registers have settled
    task automatic wait_for_valid(input string what);
        int i;
        i = 0;
        while (!data_valid) begin
            if (i == BLOCK_TIMEOUT) abort_on_timeout(what);
            @(posedge clk);
            #1;
            i++;
        end
    endtask

    task automatic wait_for_blocks(input int target, input string what);
        int i;
        int limit;
        i     = 0;
        limit = BLOCK_TIMEOUT * (target - blocks_done + 1);
        while (blocks_done < target) begin
            if (i == limit) abort_on_timeout(what);
            @(posedge clk);
            #1;
            i++;
        end
    endtask

    // Ring buffer steps after each edge that took a sample, ready toggles at random
    always @(posedge clk) begin : drive_inputs
        logic [31:0] bits;
        #1;
        if (advance_pending) begin
            take_bits(32, bits);
            ring_data       = bits;
            advance_pending = 1'b0;
        end
        take_bits(2, bits);
        data_ready = (bits[1:0] != 2'b00);
    end

    // Stream model, sampled mid-cycle for the edge that follows
    always @(negedge clk) begin : stream_model
        logic pad_frame;
        if (!reset_b) begin
            prev_valid     = 1'b0;
            prev_ready     = 1'b0;
            prev_cfg_valid = 1'b0;
            prev_cfg_ready = 1'b0;
        end else begin
            if (prev_cfg_valid && !prev_cfg_ready) check_value("config_valid", config_valid, 1);
            if (config_valid && hs_count != 0) note_failure("config_valid rose after the handshake");
            if (config_valid && config_ready) hs_count++;
            if (data_valid && hs_count == 0) note_failure("data beat offered before config");
            if (prev_valid && !prev_ready) begin
                check_value("data_valid", data_valid, 1);
                check_value("data_beat", data_beat, prev_beat);
            end
            if (ring_advance && data_valid && !data_ready) note_failure("ring moved during a stall");
            if (data_valid && data_ready) begin
                pad_frame = (beat_idx < `CC_FRAME_LEN) == (ZERO_PAD == 0);
                if (pad_frame) begin
                    check_value("data_beat.data", data_beat.data, `CC_PAD_VALUE);
                end else if (exp_ring.size() == 0) begin
                    note_failure("data frame beat with no ring sample taken for it");
                end else begin
                    check_value("data_beat.data", data_beat.data, exp_ring.pop_front());
                end
                check_value("data_beat.last", data_beat.last, beat_idx == BLOCK_LEN - 1);
                beat_idx++;
                if (beat_idx == BLOCK_LEN) begin
                    check_value("ring_advance count", block_advances, `CC_FRAME_LEN);
                    beat_idx       = 0;
                    block_advances = 0;
                    blocks_done++;
                end
            end
            if (ring_advance) begin
                exp_ring.push_back(ring_data);
                block_advances++;
                advance_pending = 1'b1;
            end
            prev_valid     = data_valid;
            prev_ready     = data_ready;
            prev_beat      = data_beat;
            prev_cfg_valid = config_valid;
            prev_cfg_ready = config_ready;
        end
    end

    initial begin : run_tests
        logic [31:0] bits;
        int          i;
        clk              = 1'b0;
        reset_b          = 1'b0;
        config_ready     = 1'b0;
        start            = 1'b0;
        data_ready       = 1'b0;
        advance_pending  = 1'b0;
        error_count      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        test_errors_base = 0;
        hs_count         = 0;
        blocks_done      = 0;
        beat_idx         = 0;
        block_advances   = 0;
        lfsr_state       = 32'h5c79;
        take_bits(3, bits);
        cfg_wait = bits + 2;
        take_bits(32, bits);
        ring_data = bits;

        repeat (3) @(posedge clk);
        #1;
        reset_b = 1'b1;
        // Block request goes in while the config handshake is still pending
        start = 1'b1;

        @(negedge clk);
        check_value("config_valid", config_valid, 0);
        check_value("data_valid", data_valid, 0);
        check_value("ring_advance", ring_advance, 0);
        @(negedge clk);
        check_value("config_valid", config_valid, 1);
        repeat (cfg_wait) @(posedge clk);
        #1;
        // Ready stays up from here, so a second request would be accepted and counted
        config_ready = 1'b1;
        i = 0;
        while (hs_count == 0) begin
            if (i == 20) abort_on_timeout("the config handshake");
            @(posedge clk);
            #1;
            i++;
        end
        finish_test("config_once");

        wait_for_valid("the first beat after config");
        start = 1'b0;
        wait_for_blocks(1, "the first block");
        finish_test("start_before_config");

        start = 1'b1;
        wait_for_valid("the first beat of a single block");
        start = 1'b0;
        wait_for_blocks(2, "a single block");
        finish_test("single_block");

        // Start held high so blocks follow each other directly
        start = 1'b1;
        wait_for_blocks(1 + BURST_BLOCKS, "back-to-back blocks");
        wait_for_valid("the final back-to-back block");
        start = 1'b0;
        wait_for_blocks(2 + BURST_BLOCKS, "the final back-to-back block");
        repeat (10) begin
            @(posedge clk);
            #1;
            check_value("data_valid", data_valid, 0);
        end
        check_value("config handshakes", hs_count, 1);
        check_value("unused ring samples", exp_ring.size(), 0);
        finish_test("back_to_back");

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/fft_stream_pkg.sv
verilog/fft_config_master.sv
cc_stream/cc_frame_sequencer.sv
cc_stream/cc_sample_streamer.sv
verilog/cc_stream_top.sv
verif/cc_stream_tb.sv

/* Bender.yml */
package:
  name: cc_stream

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fft_stream_pkg.sv
      - verilog/fft_config_master.sv
      - cc_stream/cc_frame_sequencer.sv
      - cc_stream/cc_sample_streamer.sv
      - verilog/cc_stream_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/cc_stream_tb.sv
